// ==== verilog.f ====
src/vec_pkg.sv
src/vec_bus_if.sv
src/vector_store.sv
src/scanline_rasterizer.sv
src/line_buffer.sv
src/vector_renderer_top.sv
verification/tb_vector_renderer.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, and judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_vector_renderer \
	-f verilog.f -o tb_vector_renderer > build.log 2>&1 \
	&& ./obj_dir/tb_vector_renderer > sim.log 2>&1 \
	|| echo "ERRORS FOUND" >> sim.log
cat build.log sim.log
grep -q "ERRORS FOUND" sim.log && { echo "simulation failed"; exit 1; }
echo "simulation passed"

// ==== verification/tb_vector_renderer.sv ====
`default_nettype none

module tb_vector_renderer;

	localparam int H_RES           = 64;
	localparam int V_RES           = 16;
	localparam int MAX_VECTORS     = 32;
	localparam int AW              = $clog2(MAX_VECTORS);
	localparam int CW              = vec_pkg::COORD_W;
	localparam int FRAME_PIX       = H_RES * V_RES;
	localparam int FRAMES          = 6;  // frames rendered over all tests
	localparam int WATCHDOG_CYCLES = FRAMES * FRAME_PIX * 8 * 2;
	localparam int DRIVE_DLY       = 1;

	logic                        clk = 1'b0;
	logic                        rst;
	logic                        trigger;
	logic                        host_we;
	logic [AW-1:0]               host_addr;
	vec_pkg::vector_t            host_wdata;
	logic                        fifo_full;
	logic                        fifo_write;
	logic [vec_pkg::COLOR_W-1:0] fifo_data;
	logic                        busy;

	vec_pkg::vector_t            vlist [MAX_VECTORS];  // list as the host writes it
	int                          vcount = 0;
	logic [vec_pkg::COLOR_W-1:0] exp_frame [FRAME_PIX];
	logic [vec_pkg::COLOR_W-1:0] act_frame [FRAME_PIX];
	int                          pix_cnt = 0;      // pixels accepted since reset
	int                          frame_start = 0;  // pix_cnt at the current trigger
	int                          errors = 0;
	int                          seed = 32'h512f_ccdc;
	logic [31:0]                 rnd;
	bit                          rand_full = 1'b0;

	vector_renderer_top #(
		.H_RES       (H_RES),
		.V_RES       (V_RES),
		.MAX_VECTORS (MAX_VECTORS)
	) dut_i (
		.clk        (clk),
		.rst        (rst),
		.trigger    (trigger),
		.host_we    (host_we),
		.host_addr  (host_addr),
		.host_wdata (host_wdata),
		.fifo_full  (fifo_full),
		.fifo_write (fifo_write),
		.fifo_data  (fifo_data),
		.busy       (busy)
	);

	always #4 clk = ~clk;

	// external FIFO goes full at random only when a test asks for it
	always @(posedge clk) begin
		#DRIVE_DLY;
		rnd = $random(seed);
		fifo_full = rand_full && rnd[1];
	end

	// a pixel leaves when fifo_write meets a non-full FIFO at the next edge
	always @(negedge clk) begin
		if (fifo_write && !fifo_full) begin
			if (pix_cnt - frame_start < FRAME_PIX) begin
				act_frame[pix_cnt - frame_start] = fifo_data;
			end
			pix_cnt = pix_cnt + 1;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("simulation timed out after %0d cycles, %0d errors so far", WATCHDOG_CYCLES,
			errors);
		$display("ERRORS FOUND");
		$finish;
	end

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("Error %s: expected 0x%0h, actual 0x%0h", name, exp, act);
			errors++;
		end
	endtask

	task automatic add_vec(input int x0, input int y0, input int x1, input int y1,
		input logic [15:0] col);
		vec_pkg::vector_t v;
		v.x0   = CW'(x0);
		v.y0   = CW'(y0);
		v.x1   = CW'(x1);
		v.y1   = CW'(y1);
		v.col  = col;
		v.last = 1'b0;  // set on the final entry at write time
		vlist[vcount] = v;
		vcount++;
	endtask

	task automatic write_list();
		for (int i = 0; i < vcount; i++) begin
			host_we         = 1'b1;
			host_addr       = AW'(i);
			host_wdata      = vlist[i];
			host_wdata.last = (i == vcount - 1);
			@(posedge clk);
			#DRIVE_DLY;
		end
		host_we = 1'b0;
	endtask

	// first column of a sloped segment on row y
	function automatic int row_start(input vec_pkg::vector_t v, input int y);
		int w;
		int h;
		w = int'(v.x1) - int'(v.x0);
		h = int'(v.y1) - int'(v.y0);
		if (y == int'(v.y0)) begin
			return int'(v.x0);
		end
		return int'(v.x0) + ((2 * (y - int'(v.y0)) - 1) * w + h) / (2 * h);
	endfunction

	task automatic build_expected();
		vec_pkg::vector_t v;
		int xs;
		int xe;
		for (int i = 0; i < FRAME_PIX; i++) begin
			exp_frame[i] = '0;
		end
		for (int n = 0; n < vcount; n++) begin  // later entries paint over earlier ones
			v = vlist[n];
			for (int y = int'(v.y0); y <= int'(v.y1) && y < V_RES; y++) begin
				xs = row_start(v, y);
				if (y == int'(v.y1)) begin
					xe = int'(v.x1);
				end else begin
					xe = row_start(v, y + 1) - 1;
					if (xe < xs) begin
						xe = xs;
					end
				end
				for (int x = xs; x <= xe && x < H_RES; x++) begin
					exp_frame[y * H_RES + x] = v.col;
				end
			end
		end
	endtask

	task automatic render_frame(input string name, input bit extra_trigger);
		frame_start = pix_cnt;
		trigger = 1'b1;
		@(posedge clk);
		#DRIVE_DLY;
		trigger = 1'b0;
		if (extra_trigger) begin
			while (pix_cnt - frame_start < 2 * H_RES) begin  // two scanlines already out
				@(posedge clk);
			end
			#DRIVE_DLY;
			check({name, " busy before retrigger"}, 1, busy);
			trigger = 1'b1;  // must be ignored mid-frame
			@(posedge clk);
			#DRIVE_DLY;
			trigger = 1'b0;
		end
		while (pix_cnt - frame_start < FRAME_PIX) begin
			@(posedge clk);
		end
		while (busy) begin
			@(posedge clk);
		end
		repeat (4 * H_RES) @(posedge clk);  // room for stray pixels
		#DRIVE_DLY;
		check({name, " pixel count"}, FRAME_PIX, pix_cnt - frame_start);
		check({name, " busy after frame"}, 0, busy);
	endtask

	task automatic run_list(input string name, input bit extra_trigger);
		write_list();
		build_expected();
		render_frame(name, extra_trigger);
		for (int i = 0; i < FRAME_PIX; i++) begin
			check($sformatf("%s x=%0d y=%0d", name, i % H_RES, i / H_RES),
				exp_frame[i], act_frame[i]);
		end
	endtask

	task automatic set_slope_list();
		vcount = 0;
		add_vec(2, 1, 40, 4, 16'ha001);    // shallow
		add_vec(50, 0, 53, 14, 16'ha002);  // steep
		add_vec(10, 6, 19, 15, 16'ha003);  // 45 degrees
		add_vec(30, 8, 30, 8, 16'ha004);   // single pixel
	endtask

	task automatic set_overlap_list();
		vcount = 0;
		add_vec(0, 0, 63, 15, 16'hb001);
		add_vec(40, 0, 45, 15, 16'hb002);
		add_vec(0, 7, 63, 7, 16'hb003);
	endtask

	task automatic test_horizontal();
		vcount = 0;
		add_vec(0, 0, 9, 0, 16'h1111);
		add_vec(0, 5, 63, 5, 16'h2222);  // full width
		add_vec(20, 9, 35, 9, 16'h3333);
		add_vec(60, 15, 63, 15, 16'h4444);
		run_list("test_horizontal", 1'b0);
	endtask

	task automatic test_slopes();
		set_slope_list();
		run_list("test_slopes", 1'b0);
	endtask

	task automatic test_overlap();
		set_overlap_list();
		run_list("test_overlap", 1'b0);
		// x=42 on row 7 is covered by the second and third entries
		check("test_overlap later color", 16'hb003, act_frame[7 * H_RES + 42]);
	endtask

	task automatic test_backpressure();
		set_slope_list();
		rand_full = 1'b1;
		run_list("test_backpressure", 1'b0);
		rand_full = 1'b0;
	endtask

	task automatic test_relist();
		set_overlap_list();
		add_vec(0, 15, 63, 15, 16'hc001);  // leaves the last row in the buffer
		run_list("test_relist first", 1'b0);
		vcount = 0;
		add_vec(5, 2, 8, 12, 16'hd001);
		add_vec(30, 3, 50, 3, 16'hd002);
		run_list("test_relist second", 1'b1);
	endtask

	initial begin
		rst        = 1'b1;
		trigger    = 1'b0;
		host_we    = 1'b0;
		host_addr  = '0;
		host_wdata = '0;
		fifo_full  = 1'b0;
		repeat (10) @(posedge clk);
		#DRIVE_DLY;
		rst = 1'b0;
		test_horizontal();
		test_slopes();
		test_overlap();
		test_backpressure();
		test_relist();
		$display("tests finished with %0d errors", errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== src/vector_renderer_top.sv ====
`default_nettype none

module vector_renderer_top #(
	parameter int H_RES       = 64,
	parameter int V_RES       = 16,
	parameter int MAX_VECTORS = 32
) (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           trigger,     // frame start
	input  logic                           host_we,     // single-cycle write strobe
	input  logic [$clog2(MAX_VECTORS)-1:0] host_addr,
	input  vec_pkg::vector_t               host_wdata,
	input  logic                           fifo_full,
	output logic                           fifo_write,
	output logic [vec_pkg::COLOR_W-1:0]    fifo_data,
	output logic                           busy
);

	localparam int AW = $clog2(MAX_VECTORS);

	logic                        plot;
	logic [vec_pkg::COORD_W-1:0] plot_x;
	logic [vec_pkg::COLOR_W-1:0] plot_col;
	logic                        copy;
	logic                        copy_done;

	vec_bus_if #(.AW(AW)) host_bus ();
	vec_bus_if #(.AW(AW)) rast_bus ();

	// host side always wins, so the strobe needs no grant check
	assign host_bus.req   = host_we;
	assign host_bus.we    = host_we;
	assign host_bus.addr  = host_addr;
	assign host_bus.wdata = host_wdata;

	vector_store #(.MAX_VECTORS(MAX_VECTORS)) store_i (
		.clk  (clk),
		.rst  (rst),
		.host (host_bus.arbiter),
		.rast (rast_bus.arbiter)
	);

	scanline_rasterizer #(
		.H_RES       (H_RES),
		.V_RES       (V_RES),
		.MAX_VECTORS (MAX_VECTORS)
	) rast_i (
		.clk       (clk),
		.rst       (rst),
		.trigger   (trigger),
		.vec       (rast_bus.requester),
		.plot      (plot),
		.plot_x    (plot_x),
		.plot_col  (plot_col),
		.copy      (copy),
		.copy_done (copy_done),
		.busy      (busy)
	);

	line_buffer #(.H_RES(H_RES)) lbuf_i (
		.clk        (clk),
		.rst        (rst),
		.plot       (plot),
		.plot_x     (plot_x),
		.plot_col   (plot_col),
		.copy       (copy),
		.fifo_full  (fifo_full),
		.copy_done  (copy_done),
		.fifo_write (fifo_write),
		.fifo_data  (fifo_data)
	);

endmodule

`default_nettype wire

// ==== src/line_buffer.sv ====
`default_nettype none

module line_buffer #(
	parameter int H_RES = 64
) (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        plot,
	input  logic [vec_pkg::COORD_W-1:0] plot_x,
	input  logic [vec_pkg::COLOR_W-1:0] plot_col,
	input  logic                        copy,
	input  logic                        fifo_full,
	output logic                        copy_done,
	output logic                        fifo_write,
	output logic [vec_pkg::COLOR_W-1:0] fifo_data
);

	localparam int XW = $clog2(H_RES);

	// blank at power-up, the copy erase keeps it blank afterwards
	logic [vec_pkg::COLOR_W-1:0] mem [H_RES] = '{default: '0};

	logic [XW-1:0]               rd_addr;  // copy address
	logic                        rd_en;
	logic                        rd_vld;   // rd_data holds a pixel
	logic [vec_pkg::COLOR_W-1:0] rd_data;

	assign rd_en     = copy && !fifo_full;
	assign copy_done = rd_en && (rd_addr == XW'(H_RES - 1));

	always_ff @(posedge clk) begin
		if (rst || !copy) begin
			rd_addr <= '0;
		end else if (rd_en) begin
			rd_addr <= copy_done ? '0 : rd_addr + 1'b1;
		end
	end

	// one write port, plot and copy never overlap
	always_ff @(posedge clk) begin
		if (plot) begin
			mem[plot_x[XW-1:0]] <= plot_col;
		end else if (rd_en) begin
			mem[rd_addr] <= '0;  // erase behind the read
		end
		if (rd_en) begin
			rd_data <= mem[rd_addr];  // read-first
		end
	end

	// two-stage output, both stages hold while the FIFO is full
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_vld     <= 1'b0;
			fifo_write <= 1'b0;
		end else if (!fifo_full) begin
			rd_vld     <= copy;
			fifo_write <= rd_vld;
		end
	end

	always_ff @(posedge clk) begin
		if (!fifo_full) begin
			fifo_data <= rd_data;
		end
	end

	plot_copy_a: assert property (
		@(posedge clk) disable iff (rst)
		!(plot && copy)
	);

endmodule

`default_nettype wire

// ==== src/scanline_rasterizer.sv ====
`default_nettype none

module scanline_rasterizer #(
	parameter int H_RES       = 64,
	parameter int V_RES       = 16,
	parameter int MAX_VECTORS = 32
) (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        trigger,
	vec_bus_if.requester                vec,
	output logic                        plot,
	output logic [vec_pkg::COORD_W-1:0] plot_x,
	output logic [vec_pkg::COLOR_W-1:0] plot_col,
	output logic                        copy,
	input  logic                        copy_done,
	output logic                        busy
);

	localparam int AW = $clog2(MAX_VECTORS);
	localparam int CW = vec_pkg::COORD_W;

	// steps inside DRAW
	typedef enum logic [1:0] {CLEAR, FETCH, LOAD, SPAN} step_e;

	vec_pkg::scan_state_e state;
	step_e                step;
	logic [CW-1:0]        scan_y;
	logic [AW:0]          idx;      // one spare bit so overrun shows

	vec_pkg::bres_state_t st_mem [MAX_VECTORS];  // Bresenham resume state
	vec_pkg::bres_state_t st_rd;
	vec_pkg::bres_state_t st_wdata;
	logic                 st_we;

	vec_pkg::vector_t     cur;      // vector being spanned
	logic [CW-1:0]        w;
	logic [CW-1:0]        h;
	logic [CW-1:0]        x;        // pixel plotted this cycle
	logic signed [CW:0]   e;
	logic signed [CW:0]   e_init;   // (w - h) / 2 for a fresh segment
	logic signed [CW:0]   e_dec;
	logic signed [CW:0]   e_n;
	logic signed [CW:0]   se;       // error saved for the next row
	logic [CW-1:0]        x_inc;
	logic [CW-1:0]        x_n;
	logic [CW-1:0]        sx;       // next row start column
	logic                 fin;      // span ends this cycle
	logic                 in_draw;
	logic                 ld;
	logic                 sp;
	logic                 active;   // scan_y inside the fetched vector
	logic                 vec_done;
	logic                 vec_last;

	assign in_draw = (state == vec_pkg::DRAW);
	assign ld      = in_draw && (step == LOAD);
	assign sp      = in_draw && (step == SPAN);
	assign busy    = (state != vec_pkg::SYNC);
	assign copy    = (state == vec_pkg::COPY);

	// read-only requester
	assign vec.req   = in_draw && (step == FETCH);
	assign vec.we    = 1'b0;
	assign vec.addr  = idx[AW-1:0];
	assign vec.wdata = '0;

	assign active = (scan_y >= vec.rdata.y0) && (scan_y <= vec.rdata.y1);
	assign e_init = ($signed({1'b0, vec.rdata.x1 - vec.rdata.x0})
		- $signed({1'b0, vec.rdata.y1 - vec.rdata.y0})) >>> 1;

	// step decision for the running span
	always_comb begin
		x_inc = x + 1'b1;
		e_dec = e - $signed({1'b0, h});
		x_n   = x_inc;
		e_n   = e_dec;
		sx    = x;
		se    = e + $signed({1'b0, w});
		if (scan_y == cur.y1) begin  // bottom row runs to x1
			fin = (x == cur.x1);
			e_n = e;
		end else if (e < 0) begin    // steep, next row starts here
			fin = 1'b1;
		end else begin
			fin = (e_dec < 0);
			sx  = x_inc;
			se  = e_dec + $signed({1'b0, w});
		end
	end

	assign vec_done = (ld && !active) || (sp && fin);
	assign vec_last = (step == LOAD) ? vec.rdata.last : cur.last;

	assign plot     = sp && (x < H_RES);  // no clipping, just drop
	assign plot_x   = x;
	assign plot_col = cur.col;

	always_ff @(posedge clk) begin
		if (rst) begin
			state  <= vec_pkg::SYNC;
			step   <= CLEAR;
			scan_y <= '0;
			idx    <= '0;
		end else begin
			case (state)
				vec_pkg::SYNC: if (trigger) begin
					state  <= vec_pkg::DRAW;
					step   <= CLEAR;
					scan_y <= '0;
					idx    <= '0;
				end
				vec_pkg::DRAW: begin
					if (step == CLEAR) begin
						if (idx == MAX_VECTORS - 1) begin
							idx  <= '0;
							step <= FETCH;
						end else begin
							idx <= idx + 1'b1;
						end
					end else if (step == FETCH && vec.gnt) begin
						step <= LOAD;
					end else if (ld && active) begin
						step <= SPAN;
					end else if (vec_done) begin
						if (vec_last) begin
							state <= vec_pkg::COPY;
							idx   <= '0;
						end else begin
							idx  <= idx + 1'b1;
							step <= FETCH;
						end
					end
				end
				vec_pkg::COPY: if (copy_done) begin
					step <= FETCH;
					if (scan_y == V_RES - 1) begin
						state <= vec_pkg::SYNC;
					end else begin
						scan_y <= scan_y + 1'b1;
						state  <= vec_pkg::DRAW;
					end
				end
				default: state <= vec_pkg::SYNC;
			endcase
		end
	end

	// state memory, cleared by the CLEAR sweep at frame start
	assign st_we    = in_draw && ((step == CLEAR) || (sp && fin));
	assign st_wdata = (step == CLEAR) ? '0 : {1'b1, sx, se};

	always_ff @(posedge clk) begin
		st_rd <= st_mem[idx[AW-1:0]];
		if (st_we) begin
			st_mem[idx[AW-1:0]] <= st_wdata;
		end
	end

	// span registers
	always_ff @(posedge clk) begin
		if (ld) begin
			cur <= vec.rdata;
			w   <= vec.rdata.x1 - vec.rdata.x0;
			h   <= vec.rdata.y1 - vec.rdata.y0;
			if (st_rd.valid) begin  // resume
				x <= st_rd.x;
				e <= st_rd.e;
			end else begin
				x <= vec.rdata.x0;
				e <= e_init;
			end
		end else if (sp) begin
			x <= x_n;
			e <= e_n;
		end
	end

	idx_range_a: assert property (
		@(posedge clk) disable iff (rst)
		in_draw |-> idx < MAX_VECTORS
	);

	plot_draw_a: assert property (
		@(posedge clk) disable iff (rst)
		plot |-> in_draw
	);

endmodule

`default_nettype wire

// ==== src/vector_store.sv ====
`default_nettype none

module vector_store #(
	parameter int MAX_VECTORS = 32
) (
	input  logic       clk,
	input  logic       rst,
	vec_bus_if.arbiter host,
	vec_bus_if.arbiter rast
);

	localparam int AW = $clog2(MAX_VECTORS);

	vec_pkg::vector_t mem [MAX_VECTORS];  // the vector list
	vec_pkg::vector_t rd_q;               // shared registered read port

	logic             sel_host;  // host owns the memory this cycle
	logic             any_gnt;
	logic             g_we;
	logic [AW-1:0]    g_addr;
	vec_pkg::vector_t g_wdata;

	// fixed priority, the host always wins
	always_comb begin
		sel_host = host.req;
		any_gnt  = host.req || rast.req;
		host.gnt = sel_host;
		rast.gnt = !sel_host && rast.req;
		if (sel_host) begin
			g_we    = host.we;
			g_addr  = host.addr;
			g_wdata = host.wdata;
		end else begin
			g_we    = rast.we;
			g_addr  = rast.addr;
			g_wdata = rast.wdata;
		end
	end

	// single port memory, read data held until the next granted read
	always_ff @(posedge clk) begin
		if (any_gnt) begin
			if (g_we) begin
				mem[g_addr] <= g_wdata;
			end else begin
				rd_q <= mem[g_addr];
			end
		end
	end

	assign host.rdata = rd_q;  // host only writes today
	assign rast.rdata = rd_q;

	// both requesters share one port
	gnt_onehot_a: assert property (
		@(posedge clk) disable iff (rst)
		!(host.gnt && rast.gnt)
	);

	// a starved rasterizer must keep its address stable
	rast_hold_a: assert property (
		@(posedge clk) disable iff (rst)
		rast.req && !rast.gnt |=> rast.req && $stable(rast.addr)
	);

endmodule

`default_nettype wire

// ==== src/vec_bus_if.sv ====
`default_nettype none

// one requester's port onto the shared vector-list memory
interface vec_bus_if #(
	parameter int AW = 5
);
	logic              req;    // access request, held until gnt
	logic              gnt;    // same-cycle grant
	logic              we;     // write when high
	logic [AW-1:0]     addr;   // list index
	vec_pkg::vector_t  wdata;
	vec_pkg::vector_t  rdata;  // valid one cycle after a granted read

	modport requester (
		output req,
		output we,
		output addr,
		output wdata,
		input  gnt,
		input  rdata
	);

	modport arbiter (
		input  req,
		input  we,
		input  addr,
		input  wdata,
		output gnt,
		output rdata
	);

endinterface

`default_nettype wire

// ==== src/vec_pkg.sv ====
`default_nettype none

package vec_pkg;

	// geometry and pixel widths
	parameter int COORD_W = 10;
	parameter int COLOR_W = 16;

	// one entry of the vector list, top point first
	typedef struct packed {
		logic [COORD_W-1:0] x0;    // top x
		logic [COORD_W-1:0] y0;    // top y
		logic [COORD_W-1:0] x1;    // bottom x, never left of x0
		logic [COORD_W-1:0] y1;    // bottom y, never above y0
		logic [COLOR_W-1:0] col;   // pixel color
		logic               last;  // final entry of the list
	} vector_t;

	// per-vector resume point for the next scanline
	typedef struct packed {
		logic                      valid;  // segment already started this frame
		logic [COORD_W-1:0]        x;      // first column of the next run
		logic signed [COORD_W:0]   e;      // half-scaled Bresenham error
	} bres_state_t;

	// scanline phases
	typedef enum logic [1:0] {
		SYNC,  // idle, waiting for trigger
		DRAW,  // walk the list into the line buffer
		COPY   // stream the line buffer out
	} scan_state_e;

endpackage

`default_nettype wire
